// File: design/alu.sv
`timescale 1ns/100ps

module alu (
   input  cpu_pkg::alu_op_t   i_op,
   input  cpu_pkg::word_t     i_a,
   input  cpu_pkg::word_t     i_b,
   output cpu_pkg::word_t     o_result
);
   import cpu_pkg::*;

   always_comb begin
      case (i_op)
         ALU_ADD: o_result = i_a + i_b;
         ALU_SUB: o_result = i_a - i_b;
         ALU_AND: o_result = i_a & i_b;
         ALU_OR:  o_result = i_a | i_b;
         // Unary ops on A only
         ALU_NOT: o_result = ~i_a;
         ALU_TCP: o_result = ~i_a + 1'b1;
         ALU_SHL: o_result = i_a << 1;
         // Keeps the sign bit
         ALU_SHR: o_result = word_t'($signed(i_a) >>> 1);
         // Byte of B into high half, low half cleared
         ALU_LHI: o_result = {i_b[IMM_W-1:0], {(WORD_W-IMM_W){1'b0}}};
         default: o_result = '0;
      endcase
   end

endmodule

// File: design/cpu_pkg.sv
package cpu_pkg;

   ////////////////////////////////////////////////////////////
   // Widths and instruction fields
   ////////////////////////////////////////////////////////////

   localparam int WORD_W    = 16;
   localparam int REG_IDX_W = 2;
   localparam int NUM_REGS  = 4;

   // Bit positions inside a 16-bit instruction
   localparam int OPCODE_LSB = 12;
   localparam int RS_LSB     = 10;
   localparam int RT_LSB     = 8;
   localparam int RD_LSB     = 6;
   localparam int FUNC_W     = 6;
   localparam int IMM_W      = 8;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   ////////////////////////////////////////////////////////////
   // Opcodes and function codes
   ////////////////////////////////////////////////////////////

   // I-type ALU ops
   localparam logic [WORD_W-OPCODE_LSB-1:0] OPCODE_ADI   = 4'd4;
   localparam logic [WORD_W-OPCODE_LSB-1:0] OPCODE_ORI   = 4'd5;
   localparam logic [WORD_W-OPCODE_LSB-1:0] OPCODE_LHI   = 4'd6;
   // All R-type ops share this one
   localparam logic [WORD_W-OPCODE_LSB-1:0] OPCODE_RTYPE = 4'd15;

   localparam logic [FUNC_W-1:0] FUNC_ADD = 6'd0;
   localparam logic [FUNC_W-1:0] FUNC_SUB = 6'd1;
   localparam logic [FUNC_W-1:0] FUNC_AND = 6'd2;
   localparam logic [FUNC_W-1:0] FUNC_ORR = 6'd3;
   localparam logic [FUNC_W-1:0] FUNC_NOT = 6'd4;
   localparam logic [FUNC_W-1:0] FUNC_TCP = 6'd5;
   localparam logic [FUNC_W-1:0] FUNC_SHL = 6'd6;
   localparam logic [FUNC_W-1:0] FUNC_SHR = 6'd7;
   // Output port write and halt
   localparam logic [FUNC_W-1:0] FUNC_WWD = 6'd28;
   localparam logic [FUNC_W-1:0] FUNC_HLT = 6'd29;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_NOT,
      ALU_TCP,
      ALU_SHL,
      ALU_SHR,
      ALU_LHI
   } alu_op_t;

   ////////////////////////////////////////////////////////////
   // Instruction view and stage payloads
   ////////////////////////////////////////////////////////////

   // Immediate lives in the low IMM_W bits
   typedef struct packed {
      logic [WORD_W-1:OPCODE_LSB]     opcode;
      logic [OPCODE_LSB-1:RS_LSB]     rs;
      logic [RS_LSB-1:RT_LSB]         rt;
      logic [RT_LSB-1:RD_LSB]         rd;
      logic [FUNC_W-1:0]              func;
   } inst_t;

   typedef struct packed {
      logic     valid;
      alu_op_t  alu_op;
      logic     use_imm;
      word_t    imm;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    rs_data;
      word_t    rt_data;
      reg_idx_t dst;
      logic     reg_write;
      logic     out_write;
      logic     halt;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      word_t    result;
      reg_idx_t dst;
      logic     reg_write;
      logic     halt;
   } ex_wb_t;

   typedef struct packed {
      logic     en;
      reg_idx_t addr;
      word_t    data;
   } rf_write_t;

endpackage

// File: design/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 i_inst_valid,
   input  cpu_pkg::inst_t       i_inst,
   output logic                 o_out_valid,
   output cpu_pkg::word_t       o_out_data,
   output logic                 o_halted
);
   import cpu_pkg::*;

   // Stage payloads
   id_ex_t    id_ex;
   ex_wb_t    ex_wb;
   rf_write_t rf_write;

   // Register file read path
   reg_idx_t  rs_addr;
   reg_idx_t  rt_addr;
   word_t     rs_data;
   word_t     rt_data;

   logic      ex_halt;

   ////////////////////////////////////////////////////////////
   // Pipeline stages
   ////////////////////////////////////////////////////////////

   decode_stage u_decode (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_inst_valid (i_inst_valid),
      .i_inst       (i_inst),
      .i_rs_data    (rs_data),
      .i_rt_data    (rt_data),
      .o_rs_addr    (rs_addr),
      .o_rt_addr    (rt_addr),
      .o_id_ex      (id_ex)
   );

   // Forwarding taps the writeback request
   execute_stage u_execute (
      .clk         (clk),
      .reset_n     (reset_n),
      .i_id_ex     (id_ex),
      .i_fwd       (rf_write),
      .o_ex_wb     (ex_wb),
      .o_out_valid (o_out_valid),
      .o_out_data  (o_out_data),
      .o_halt      (ex_halt)
   );

   writeback_stage u_writeback (
      .clk      (clk),
      .reset_n  (reset_n),
      .i_ex_wb  (ex_wb),
      .i_halt   (ex_halt),
      .o_write  (rf_write),
      .o_halted (o_halted)
   );

   register_file u_regfile (
      .clk       (clk),
      .reset_n   (reset_n),
      .i_write   (rf_write),
      .i_rs_addr (rs_addr),
      .i_rt_addr (rt_addr),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data)
   );

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 i_inst_valid,
   input  cpu_pkg::inst_t       i_inst,
   input  cpu_pkg::word_t       i_rs_data,
   input  cpu_pkg::word_t       i_rt_data,
   output cpu_pkg::reg_idx_t    o_rs_addr,
   output cpu_pkg::reg_idx_t    o_rt_addr,
   output cpu_pkg::id_ex_t      o_id_ex
);
   import cpu_pkg::*;

   ////////////////////////////////////////////////////////////
   // Instruction register and acceptance
   ////////////////////////////////////////////////////////////

   inst_t ir;
   logic  ir_valid;
   logic  halt_seen;
   logic  accept;
   logic  inst_is_hlt;

   // Nothing gets in once a HLT has been taken
   assign accept      = i_inst_valid && !halt_seen;
   assign inst_is_hlt = (i_inst.opcode == OPCODE_RTYPE) && (i_inst.func == FUNC_HLT);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         ir        <= '0;
         ir_valid  <= 1'b0;
         halt_seen <= 1'b0;
      end else begin
         ir_valid <= accept;
         if (accept) begin
            ir <= i_inst;
         end
         // Sticky until reset
         if (accept && inst_is_hlt) begin
            halt_seen <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Field decode and control
   ////////////////////////////////////////////////////////////

   alu_op_t  alu_op;
   logic     use_imm;
   word_t    imm_ext;
   reg_idx_t dst;
   logic     reg_write;
   logic     out_write;
   logic     halt;

   always_comb begin
      // R-type dest and no side effects by default
      alu_op    = ALU_ADD;
      use_imm   = 1'b0;
      imm_ext   = '0;
      dst       = ir.rd;
      reg_write = 1'b0;
      out_write = 1'b0;
      halt      = 1'b0;
      case (ir.opcode)
         OPCODE_ADI: begin
            alu_op    = ALU_ADD;
            use_imm   = 1'b1;
            // Sign-extended
            imm_ext   = {{(WORD_W-IMM_W){ir[IMM_W-1]}}, ir[IMM_W-1:0]};
            dst       = ir.rt;
            reg_write = 1'b1;
         end
         OPCODE_ORI: begin
            alu_op    = ALU_OR;
            use_imm   = 1'b1;
            // Zero-extended
            imm_ext   = {{(WORD_W-IMM_W){1'b0}}, ir[IMM_W-1:0]};
            dst       = ir.rt;
            reg_write = 1'b1;
         end
         OPCODE_LHI: begin
            // ALU moves the byte up
            alu_op    = ALU_LHI;
            use_imm   = 1'b1;
            imm_ext   = {{(WORD_W-IMM_W){1'b0}}, ir[IMM_W-1:0]};
            dst       = ir.rt;
            reg_write = 1'b1;
         end
         OPCODE_RTYPE: begin
            reg_write = 1'b1;
            case (ir.func)
               FUNC_ADD: alu_op = ALU_ADD;
               FUNC_SUB: alu_op = ALU_SUB;
               FUNC_AND: alu_op = ALU_AND;
               FUNC_ORR: alu_op = ALU_OR;
               FUNC_NOT: alu_op = ALU_NOT;
               FUNC_TCP: alu_op = ALU_TCP;
               FUNC_SHL: alu_op = ALU_SHL;
               FUNC_SHR: alu_op = ALU_SHR;
               FUNC_WWD: begin
                  reg_write = 1'b0;
                  out_write = 1'b1;
               end
               FUNC_HLT: begin
                  reg_write = 1'b0;
                  halt      = 1'b1;
               end
               // Unknown function writes nothing
               default:  reg_write = 1'b0;
            endcase
         end
         default: ;
      endcase
   end

   // Register file addressed straight from IR
   assign o_rs_addr = ir.rs;
   assign o_rt_addr = ir.rt;

   ////////////////////////////////////////////////////////////
   // ID/EX pipeline register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Bubble carries an all-zero payload
      if (!reset_n || !ir_valid) begin
         o_id_ex <= '0;
      end else begin
         o_id_ex.valid     <= 1'b1;
         o_id_ex.alu_op    <= alu_op;
         o_id_ex.use_imm   <= use_imm;
         o_id_ex.imm       <= imm_ext;
         o_id_ex.rs        <= ir.rs;
         o_id_ex.rt        <= ir.rt;
         o_id_ex.rs_data   <= i_rs_data;
         o_id_ex.rt_data   <= i_rt_data;
         o_id_ex.dst       <= dst;
         o_id_ex.reg_write <= reg_write;
         o_id_ex.out_write <= out_write;
         o_id_ex.halt      <= halt;
      end
   end

endmodule

// File: design/execute_stage.sv
`timescale 1ns/100ps

module execute_stage (
   input  logic                 clk,
   input  logic                 reset_n,
   input  cpu_pkg::id_ex_t      i_id_ex,
   input  cpu_pkg::rf_write_t   i_fwd,
   output cpu_pkg::ex_wb_t      o_ex_wb,
   output logic                 o_out_valid,
   output cpu_pkg::word_t       o_out_data,
   output logic                 o_halt
);
   import cpu_pkg::*;

   ////////////////////////////////////////////////////////////
   // Forwarding and operand select
   ////////////////////////////////////////////////////////////

   word_t rs_val;
   word_t rt_val;
   word_t op_b;
   word_t alu_result;
   logic  do_out;
   logic  do_halt;

   // Writeback result overrides a stale read
   function automatic word_t fwd_sel(input reg_idx_t idx, input word_t read_val,
                                     input rf_write_t wr);
      word_t value;
      value = read_val;
      if (wr.en && (wr.addr == idx)) begin
         value = wr.data;
      end
      return value;
   endfunction

   assign rs_val = fwd_sel(i_id_ex.rs, i_id_ex.rs_data, i_fwd);
   assign rt_val = fwd_sel(i_id_ex.rt, i_id_ex.rt_data, i_fwd);

   // B is either rt or the extended immediate
   assign op_b = i_id_ex.use_imm ? i_id_ex.imm : rt_val;

   alu u_alu (
      .i_op     (i_id_ex.alu_op),
      .i_a      (rs_val),
      .i_b      (op_b),
      .o_result (alu_result)
   );

   assign do_out  = i_id_ex.valid && i_id_ex.out_write;
   assign do_halt = i_id_ex.valid && i_id_ex.halt;

   ////////////////////////////////////////////////////////////
   // EX/WB register and output port
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         o_ex_wb     <= '0;
         o_out_valid <= 1'b0;
         o_out_data  <= '0;
         o_halt      <= 1'b0;
      end else begin
         o_ex_wb.valid     <= i_id_ex.valid;
         o_ex_wb.result    <= alu_result;
         o_ex_wb.dst       <= i_id_ex.dst;
         o_ex_wb.reg_write <= i_id_ex.valid && i_id_ex.reg_write;
         o_ex_wb.halt      <= do_halt;
         // One-cycle pulse per WWD
         o_out_valid <= do_out;
         // Port holds its last value
         if (do_out) begin
            o_out_data <= rs_val;
         end
         o_halt <= do_halt;
      end
   end

endmodule

// File: design/register_file.sv
`timescale 1ns/100ps

module register_file (
   input  logic                 clk,
   input  logic                 reset_n,
   input  cpu_pkg::rf_write_t   i_write,
   input  cpu_pkg::reg_idx_t    i_rs_addr,
   input  cpu_pkg::reg_idx_t    i_rt_addr,
   output cpu_pkg::word_t       o_rs_data,
   output cpu_pkg::word_t       o_rt_data
);
   import cpu_pkg::*;

   // Four architectural registers
   word_t regs_q [NUM_REGS];

   // Read with write-through bypass
   function automatic word_t read_port(input reg_idx_t addr, input rf_write_t wr,
                                       input word_t stored);
      word_t value;
      value = stored;
      // Same-cycle write wins over the stored copy
      if (wr.en && (wr.addr == addr)) begin
         value = wr.data;
      end
      return value;
   endfunction

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (i_write.en) begin
         regs_q[i_write.addr] <= i_write.data;
      end
   end

   // Both ports see the pending write
   assign o_rs_data = read_port(i_rs_addr, i_write, regs_q[i_rs_addr]);
   assign o_rt_data = read_port(i_rt_addr, i_write, regs_q[i_rt_addr]);

endmodule

// File: design/writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
   input  logic                 clk,
   input  logic                 reset_n,
   input  cpu_pkg::ex_wb_t      i_ex_wb,
   input  logic                 i_halt,
   output cpu_pkg::rf_write_t   o_write,
   output logic                 o_halted
);
   import cpu_pkg::*;

   logic halted_q;

   ////////////////////////////////////////////////////////////
   // Register write request
   ////////////////////////////////////////////////////////////

   // Also feeds execute forwarding
   always_comb begin
      o_write.en   = i_ex_wb.valid && i_ex_wb.reg_write;
      o_write.addr = i_ex_wb.dst;
      o_write.data = i_ex_wb.result;
   end

   ////////////////////////////////////////////////////////////
   // Halt state
   ////////////////////////////////////////////////////////////

   // Held once the HLT reaches writeback
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         halted_q <= 1'b0;
      end else if (i_ex_wb.valid && i_ex_wb.halt) begin
         halted_q <= 1'b1;
      end
   end

   // Pulse from execute shows up the same cycle
   assign o_halted = i_halt || halted_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f vlog.f \
   --Mdir obj_dir -o tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_cpu_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit "$status"
fi

exit 0

// File: testbench/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

////////////////////////////////////////////////////////////
// Instruction-set model state
////////////////////////////////////////////////////////////

word_t model_regs [4];
// WWD values in order, with the edge each one is due on
word_t exp_data_q [$];
int    exp_edge_q [$];
logic  model_halted;
int    halt_edge;

// Kinds 0 to 7 are R-type ALU ops, then ADI, ORI and LHI
function automatic inst_t encode_alu(input int kind, input reg_idx_t rs, input reg_idx_t rt,
                                     input reg_idx_t rd, input logic [7:0] imm);
   logic [5:0] func;
   word_t      bits;
   case (kind)
      0:       func = FUNC_ADD;
      1:       func = FUNC_SUB;
      2:       func = FUNC_AND;
      3:       func = FUNC_ORR;
      4:       func = FUNC_NOT;
      5:       func = FUNC_TCP;
      6:       func = FUNC_SHL;
      default: func = FUNC_SHR;
   endcase
   case (kind)
      8:       bits = {OPCODE_ADI, rs, rt, imm};
      9:       bits = {OPCODE_ORI, rs, rt, imm};
      10:      bits = {OPCODE_LHI, rs, rt, imm};
      default: bits = {OPCODE_RTYPE, rs, rt, rd, func};
   endcase
   return inst_t'(bits);
endfunction

// WWD and HLT only use rs
function automatic inst_t encode_special(input logic [5:0] func, input reg_idx_t rs);
   word_t bits;
   bits = {OPCODE_RTYPE, rs, 2'b00, 2'b00, func};
   return inst_t'(bits);
endfunction

// I-type writes rt, R-type writes rd
function automatic reg_idx_t dest_of(input int kind, input reg_idx_t rt, input reg_idx_t rd);
   return (kind >= 8) ? rt : rd;
endfunction

function automatic inst_t random_alu();
   int         kind;
   reg_idx_t   rs;
   reg_idx_t   rt;
   reg_idx_t   rd;
   logic [7:0] imm;
   kind = random_bits(4) % 11;
   rs   = reg_idx_t'(random_bits(2));
   rt   = reg_idx_t'(random_bits(2));
   rd   = reg_idx_t'(random_bits(2));
   imm  = 8'(random_bits(8));
   return encode_alu(kind, rs, rt, rd, imm);
endfunction

// Runs one accepted instruction on the model registers
function automatic void execute_model(input inst_t inst, input int accept_edge);
   word_t      a;
   word_t      b;
   word_t      res;
   logic [7:0] imm;
   logic       write_en;
   reg_idx_t   dst;
   a        = model_regs[inst.rs];
   b        = model_regs[inst.rt];
   imm      = {inst.rd, inst.func};
   res      = '0;
   write_en = 1'b1;
   dst      = inst.rt;
   case (inst.opcode)
      OPCODE_ADI: res = a + {{8{imm[7]}}, imm};
      OPCODE_ORI: res = a | {8'h00, imm};
      OPCODE_LHI: res = {imm, 8'h00};
      OPCODE_RTYPE: begin
         dst = inst.rd;
         case (inst.func)
            FUNC_ADD: res = a + b;
            FUNC_SUB: res = a - b;
            FUNC_AND: res = a & b;
            FUNC_ORR: res = a | b;
            FUNC_NOT: res = ~a;
            FUNC_TCP: res = 16'd0 - a;
            FUNC_SHL: res = {a[14:0], 1'b0};
            FUNC_SHR: res = {a[15], a[15:1]};
            FUNC_WWD: begin
               write_en = 1'b0;
               // Port shows rs two edges after acceptance
               exp_data_q.push_back(a);
               exp_edge_q.push_back(accept_edge + 2);
            end
            FUNC_HLT: begin
               write_en     = 1'b0;
               model_halted = 1'b1;
               halt_edge    = accept_edge + 2;
            end
            default: write_en = 1'b0;
         endcase
      end
      default: write_en = 1'b0;
   endcase
   if (write_en) begin
      model_regs[dst] = res;
   end
endfunction

`endif

// File: testbench/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
   import cpu_pkg::*;

   localparam int RESET_CYCLES    = 10;
   localparam int DRIVE_DELAY     = 10;
   localparam int SAMPLE_DELAY    = 30;
   localparam int LOAD_COUNT      = 8;
   localparam int ALU_COUNT       = 22;
   localparam int DENSE_COUNT     = 40;
   localparam int BUBBLE_COUNT    = 40;
   localparam int HALT_COUNT      = 6;
   localparam int SETTLE_CYCLES   = 4;
   localparam int INST_COUNT      = LOAD_COUNT + ALU_COUNT + DENSE_COUNT + BUBBLE_COUNT
                                    + HALT_COUNT;
   localparam int WATCHDOG_CYCLES = INST_COUNT * 3 + 40;

   logic        clk;
   logic        reset_n;
   logic        i_inst_valid;
   inst_t       i_inst;
   logic        o_out_valid;
   word_t       o_out_data;
   logic        o_halted;

   logic [31:0] lfsr_state;
   int          edge_num;
   string       test_name;
   // Port value the DUT should be holding
   word_t       last_out;

   cpu_top i_dut (
      .clk          (clk),
      .reset_n      (reset_n),
      .i_inst_valid (i_inst_valid),
      .i_inst       (i_inst),
      .o_out_valid  (o_out_valid),
      .o_out_data   (o_out_data),
      .o_halted     (o_halted)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////
   // Random numbers
   ////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic step_lfsr();
      logic feedback;
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      return feedback;
   endfunction

   function automatic int random_bits(input int count);
      int value;
      value = 0;
      for (int i = 0; i < count; i++) begin
         value = (value << 1) | int'(step_lfsr());
      end
      return value;
   endfunction

   function automatic word_t random_word();
      return word_t'(random_bits(WORD_W));
   endfunction

   // Idle cycles before an instruction
   function automatic int pick_gap();
      return random_bits(2) % 3;
   endfunction

   `include "cpu_model.svh"

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string what, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         $display("FAILED %s %s expected %h actual %h", test_name, what, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "Wrong value on %s", what);
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("FAILED %s %s expected %b actual %b", test_name, what, expected, actual);
         $display("TESTS FAILED");
         $fatal(1, "Wrong value on %s", what);
      end
   endtask

   // Outputs registered on edge edge_num
   task automatic check_outputs();
      logic exp_valid;
      logic exp_halted;
      exp_valid = (exp_edge_q.size() > 0) && (exp_edge_q[0] == edge_num);
      if (exp_valid) begin
         last_out = exp_data_q.pop_front();
         void'(exp_edge_q.pop_front());
      end
      check_flag("o_out_valid", exp_valid, o_out_valid);
      check_word("o_out_data", last_out, o_out_data);
      exp_halted = model_halted && (edge_num >= halt_edge);
      check_flag("o_halted", exp_halted, o_halted);
   endtask

   ////////////////////////////////////////////////////////////
   // Cycle driver
   ////////////////////////////////////////////////////////////

   task automatic run_cycle(input logic valid, input inst_t inst);
      @(posedge clk);
      edge_num++;
      #(DRIVE_DELAY);
      // Released after the tenth edge
      reset_n      = (edge_num >= RESET_CYCLES);
      i_inst_valid = valid;
      i_inst       = inst;
      // Taken on the next edge unless a HLT got in first
      if (valid && reset_n && !model_halted) begin
         execute_model(inst, edge_num + 1);
      end
      #(SAMPLE_DELAY);
      check_outputs();
   endtask

   // Junk on i_inst while invalid
   task automatic send_inst(input inst_t inst, input int gap);
      for (int i = 0; i < gap; i++) begin
         run_cycle(1'b0, inst_t'(random_word()));
      end
      run_cycle(1'b1, inst);
   endtask

   ////////////////////////////////////////////////////////////
   // Test phases
   ////////////////////////////////////////////////////////////

   task automatic run_alu_ops();
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [7:0] imm;
      test_name = "alu_ops";
      // LHI then ORI gives each register a random word
      for (int r = 0; r < 4; r++) begin
         imm = 8'(random_bits(8));
         send_inst(encode_alu(10, 2'd0, reg_idx_t'(r), 2'd0, imm), pick_gap());
         imm = 8'(random_bits(8));
         send_inst(encode_alu(9, reg_idx_t'(r), reg_idx_t'(r), 2'd0, imm), pick_gap());
      end
      // Every op read out by a WWD
      for (int kind = 0; kind < 11; kind++) begin
         rs  = reg_idx_t'(random_bits(2));
         rt  = reg_idx_t'(random_bits(2));
         rd  = reg_idx_t'(random_bits(2));
         imm = 8'(random_bits(8));
         send_inst(encode_alu(kind, rs, rt, rd, imm), pick_gap());
         send_inst(encode_special(FUNC_WWD, dest_of(kind, rt, rd)), pick_gap());
      end
   endtask

   task automatic run_dense();
      reg_idx_t   last_dst;
      reg_idx_t   prev_dst;
      reg_idx_t   src;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [7:0] imm;
      int         sel;
      int         kind;
      test_name = "forwarding";
      last_dst  = 2'd0;
      prev_dst  = 2'd1;
      for (int n = 0; n < DENSE_COUNT; n++) begin
         sel = random_bits(2);
         // Source from one or two producers back or any register
         if (sel == 0) begin
            src = last_dst;
         end else if (sel == 1) begin
            src = prev_dst;
         end else begin
            src = reg_idx_t'(random_bits(2));
         end
         if (random_bits(2) == 0) begin
            send_inst(encode_special(FUNC_WWD, src), 0);
         end else begin
            kind = random_bits(4) % 11;
            rt   = (sel == 0) ? prev_dst : reg_idx_t'(random_bits(2));
            rd   = reg_idx_t'(random_bits(2));
            imm  = 8'(random_bits(8));
            send_inst(encode_alu(kind, src, rt, rd, imm), 0);
            prev_dst = last_dst;
            last_dst = dest_of(kind, rt, rd);
         end
      end
   endtask

   task automatic run_bubbles();
      inst_t inst;
      test_name = "bubbles";
      for (int n = 0; n < BUBBLE_COUNT; n++) begin
         if (random_bits(2) == 0) begin
            inst = encode_special(FUNC_WWD, reg_idx_t'(random_bits(2)));
         end else begin
            inst = random_alu();
         end
         send_inst(inst, pick_gap());
      end
   endtask

   task automatic run_halt();
      test_name = "halt";
      send_inst(encode_special(FUNC_WWD, 2'd0), 0);
      send_inst(encode_special(FUNC_HLT, 2'd0), 0);
      // Back-to-back WWDs after the HLT are all dropped
      for (int n = 0; n < HALT_COUNT - 2; n++) begin
         send_inst(encode_special(FUNC_WWD, reg_idx_t'(random_bits(2))), 0);
      end
      // Until the DUT reports halt with nothing left due
      while (!(o_halted === 1'b1 && exp_data_q.size() == 0)) begin
         run_cycle(1'b0, inst_t'(random_word()));
      end
      // Halt stays up and the port stays quiet
      for (int n = 0; n < SETTLE_CYCLES; n++) begin
         send_inst(encode_special(FUNC_WWD, reg_idx_t'(random_bits(2))), 0);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence and watchdog
   ////////////////////////////////////////////////////////////

   initial begin
      reset_n      = 1'b0;
      i_inst_valid = 1'b0;
      i_inst       = '0;
      lfsr_state   = 32'd32;
      edge_num     = 0;
      last_out     = '0;
      test_name    = "reset";
      model_halted = 1'b0;
      halt_edge    = 0;
      for (int r = 0; r < 4; r++) begin
         model_regs[r] = '0;
      end
      // Reset cycles plus one idle cycle after release
      for (int n = 0; n <= RESET_CYCLES; n++) begin
         run_cycle(1'b0, '0);
      end
      run_alu_ops();
      run_dense();
      run_bubbles();
      run_halt();
      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("TESTS FAILED");
      $fatal(1, "Timeout after %0d cycles without finishing", WATCHDOG_CYCLES);
   end

endmodule

// File: vlog.f
+incdir+testbench
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/writeback_stage.sv
design/cpu_top.sv
testbench/tb_cpu.sv
